// ==== xt_periph_pkg.sv ====
// Shared types and constants for the XT peripheral glue logic
// CPU bus, chip selects, device read data and EMS mapping entries

package xt_periph_pkg;

    // CPU side bus as seen by the peripheral block
    typedef struct packed {
        logic [19:0] address;
        logic [7:0]  data;
        logic        io_read_n;
        logic        io_write_n;
        logic        memory_read_n;
        logic        address_enable_n;
    } cpu_bus_t;

    // Decoded selects, legacy devices active low
    typedef struct packed {
        logic dma_n;
        logic pic_n;
        logic pit_n;
        logic ppi_n;
        logic dma_page_n;
        logic ems;
    } chip_select_t;

    // Read data from the external 8259, 8253 and 8255
    typedef struct packed {
        logic [7:0] pic;
        logic [7:0] pit;
        logic [7:0] ppi;
    } device_rdata_t;

    // One EMS window mapping
    typedef struct packed {
        logic       enable;
        logic [6:0] page;
    } ems_entry_t;

    localparam int          IO_GROUP_SHIFT    = 5;
    localparam logic [15:0] EMS_PORT_BASE     = 16'h0260;
    localparam logic [7:0]  EMS_DISABLE_CODE  = 8'hFF;
    localparam logic [7:0]  EMS_PAGE_LIMIT    = 8'h80;
    localparam logic [7:0]  EMS_UNMAPPED_READ = 8'hFF;
    localparam int          EMS_WINDOWS       = 4;
    localparam logic [7:0]  IDLE_BUS_DATA     = 8'h00;

    // Segment nibble per ems_address: A000, C000, D000, E000
    localparam logic [3:0][3:0] EMS_SEGMENT_BASES = {4'hE, 4'hD, 4'hC, 4'hA};

endpackage

// ==== io_decode.sv ====
// I/O port chip-select decode
// 32-port groups of the low I/O space plus the EMS register block

`timescale 1ns/10ps

module io_decode import xt_periph_pkg::*; (
    input  cpu_bus_t     bus_i,
    input  logic         ems_enable_i,
    output chip_select_t cs_o
);

    logic       io_cycle;
    logic       low_io_space;
    logic [2:0] group;

    assign io_cycle     = ~bus_i.address_enable_n;
    assign low_io_space = io_cycle && (bus_i.address[9:8] == 2'b00);
    assign group        = bus_i.address[IO_GROUP_SHIFT +: 3];

    always_comb begin
        cs_o.dma_n      = 1'b1;
        cs_o.pic_n      = 1'b1;
        cs_o.pit_n      = 1'b1;
        cs_o.ppi_n      = 1'b1;
        cs_o.dma_page_n = 1'b1;

        if (low_io_space) begin
            case (group)
                3'd0:    cs_o.dma_n      = 1'b0;
                3'd1:    cs_o.pic_n      = 1'b0;
                3'd2:    cs_o.pit_n      = 1'b0;
                3'd3:    cs_o.ppi_n      = 1'b0;
                3'd4:    cs_o.dma_page_n = 1'b0;
                // Groups 5 to 7 are unused here
                default: ;
            endcase
        end

        // Four EMS registers from 0x260
        cs_o.ems = io_cycle && ems_enable_i
                   && ({bus_i.address[15:2], 2'b00} == EMS_PORT_BASE);
    end

endmodule

// ==== ems_mapper.sv ====
// EMS page mapping registers
// Port writes, readback byte and the four segment window hits

`timescale 1ns/10ps

module ems_mapper import xt_periph_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    input  cpu_bus_t     bus_i,
    input  chip_select_t cs_i,
    input  logic [1:0]   ems_address_i,
    output logic [7:0]   readback_o,
    output logic [3:0]   window_hit_o
);

    ems_entry_t entries_q [EMS_WINDOWS];
    ems_entry_t selected_entry;
    logic       write_en;
    logic [1:0] entry_index;
    logic [3:0] segment_base;

    assign write_en    = cs_i.ems && ~bus_i.io_write_n;
    assign entry_index = bus_i.address[1:0];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < EMS_WINDOWS; i++) begin
                entries_q[i] <= '0;
            end
        end else if (write_en) begin
            if (bus_i.data == EMS_DISABLE_CODE) begin
                // Unmap the window
                entries_q[entry_index].enable <= 1'b0;
                entries_q[entry_index].page   <= 7'h7F;
            end else if (bus_i.data < EMS_PAGE_LIMIT) begin
                entries_q[entry_index].enable <= 1'b1;
                entries_q[entry_index].page   <= bus_i.data[6:0];
            end
            // Values 0x80 to 0xFE are ignored
        end
    end

    // Readback of the addressed entry
    assign selected_entry = entries_q[entry_index];
    assign readback_o     = selected_entry.enable ? {1'b0, selected_entry.page}
                                                  : EMS_UNMAPPED_READ;

    assign segment_base = EMS_SEGMENT_BASES[ems_address_i];

    // One 16 KB window per entry inside the chosen 64 KB segment
    for (genvar w = 0; w < EMS_WINDOWS; w++) begin : g_window
        assign window_hit_o[w] = entries_q[w].enable
                                 && (bus_i.address[19:14] == {segment_base, 2'(w)});
    end

endmodule

// ==== cdc_sync.sv ====
// Two-stage synchronizer for a level of any payload type

`timescale 1ns/10ps

module cdc_sync #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t meta_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            meta_q <= '0;
            data_o <= '0;
        end else begin
            meta_q <= data_i;
            data_o <= meta_q;
        end
    end

endmodule

// ==== peripheral_crossing.sv ====
// Peripheral clock domain crossings
// Timer clock divider, keycode and keyboard IRQ into the CPU domain,
// PPI keyboard controls into the peripheral domain

`timescale 1ns/10ps

module peripheral_crossing (
    input  logic       clock,
    input  logic       peripheral_clock,
    input  logic       reset,
    input  logic [7:0] keycode_i,
    input  logic       keyboard_irq_i,
    input  logic       send_clock_i,
    input  logic [7:0] port_b_i,
    output logic       timer_clock_o,
    output logic       keyboard_interrupt_o,
    output logic [7:0] keycode_o,
    output logic       kbd_send_request_o,
    output logic       ps2_clock_out_o
);

    // PPI port B bits 7 and 6
    typedef struct packed {
        logic clear_keycode;
        logic kbd_reset;
    } ppi_ctrl_t;

    logic      timer_toggle_q;
    ppi_ctrl_t ppi_ctrl_sync;
    logic      kbd_reset_prev_q;

    // Timer input is peripheral_clock divided by two
    always_ff @(posedge peripheral_clock) begin
        if (reset) begin
            timer_toggle_q <= 1'b0;
        end else begin
            timer_toggle_q <= ~timer_toggle_q;
        end
    end

    cdc_sync #(.payload_t(logic)) u_timer_sync (
        .clock  (clock),
        .reset  (reset),
        .data_i (timer_toggle_q),
        .data_o (timer_clock_o)
    );

    cdc_sync #(.payload_t(logic [7:0])) u_keycode_sync (
        .clock  (clock),
        .reset  (reset),
        .data_i (keycode_i),
        .data_o (keycode_o)
    );

    cdc_sync #(.payload_t(logic)) u_kbd_irq_sync (
        .clock  (clock),
        .reset  (reset),
        .data_i (keyboard_irq_i),
        .data_o (keyboard_interrupt_o)
    );

    // Controls from the CPU domain PPI
    cdc_sync #(.payload_t(ppi_ctrl_t)) u_ppi_ctrl_sync (
        .clock  (peripheral_clock),
        .reset  (reset),
        .data_i (ppi_ctrl_t'(port_b_i[7:6])),
        .data_o (ppi_ctrl_sync)
    );

    always_ff @(posedge peripheral_clock) begin
        if (reset) begin
            kbd_reset_prev_q   <= 1'b0;
            kbd_send_request_o <= 1'b0;
            ps2_clock_out_o    <= 1'b1;
        end else begin
            kbd_reset_prev_q   <= ppi_ctrl_sync.kbd_reset;
            // Rising edge of keyboard reset starts a reset command
            kbd_send_request_o <= ppi_ctrl_sync.kbd_reset & ~kbd_reset_prev_q;
            // Hold the PS/2 clock low while a key is pending or reset is held
            ps2_clock_out_o    <= ~keyboard_irq_i & send_clock_i & ppi_ctrl_sync.kbd_reset;
        end
    end

endmodule

// ==== read_data_mux.sv ====
// CPU read data selection with fixed priority and drive flag

`timescale 1ns/10ps

module read_data_mux import xt_periph_pkg::*; (
    input  cpu_bus_t      bus_i,
    input  logic          interrupt_acknowledge_n_i,
    input  chip_select_t  cs_i,
    input  device_rdata_t device_rdata_i,
    input  logic [7:0]    ems_readback_i,
    output logic [7:0]    data_bus_o,
    output logic          data_bus_drive_o
);

    logic io_read;

    assign io_read = ~bus_i.io_read_n;

    always_comb begin
        data_bus_drive_o = 1'b1;
        if (~interrupt_acknowledge_n_i) begin
            // Vector from the 8259 during INTA
            data_bus_o = device_rdata_i.pic;
        end else if (~cs_i.pic_n && io_read) begin
            data_bus_o = device_rdata_i.pic;
        end else if (~cs_i.pit_n && io_read) begin
            data_bus_o = device_rdata_i.pit;
        end else if (~cs_i.ppi_n && io_read) begin
            data_bus_o = device_rdata_i.ppi;
        end else if (cs_i.ems && io_read) begin
            data_bus_o = ems_readback_i;
        end else begin
            data_bus_drive_o = 1'b0;
            data_bus_o       = IDLE_BUS_DATA;
        end
    end

endmodule

// ==== xt_peripherals.sv ====
// Top level of the XT peripheral glue logic
// Port decode, EMS mapper, read data mux and clock domain crossings

`timescale 1ns/10ps

module xt_peripherals import xt_periph_pkg::*; (
    input  logic          clock,
    input  logic          peripheral_clock,
    input  logic          reset,
    // CPU bus
    input  cpu_bus_t      cpu_bus_i,
    input  logic          ems_enable_i,
    input  logic [1:0]    ems_address_i,
    input  logic          interrupt_acknowledge_n_i,
    input  device_rdata_t device_rdata_i,
    // Keyboard side
    input  logic [7:0]    keycode_i,
    input  logic          keyboard_irq_i,
    input  logic          send_clock_i,
    input  logic [7:0]    port_b_i,
    // Outputs
    output chip_select_t  cs_o,
    output logic [3:0]    ems_window_hit_o,
    output logic [7:0]    data_bus_o,
    output logic          data_bus_drive_o,
    output logic          timer_clock_o,
    output logic          keyboard_interrupt_o,
    output logic [7:0]    keycode_o,
    output logic          kbd_send_request_o,
    output logic          ps2_clock_out_o
);

    logic [7:0] ems_readback;

    io_decode u_io_decode (
        .bus_i        (cpu_bus_i),
        .ems_enable_i (ems_enable_i),
        .cs_o         (cs_o)
    );

    ems_mapper u_ems_mapper (
        .clock         (clock),
        .reset         (reset),
        .bus_i         (cpu_bus_i),
        .cs_i          (cs_o),
        .ems_address_i (ems_address_i),
        .readback_o    (ems_readback),
        .window_hit_o  (ems_window_hit_o)
    );

    read_data_mux u_read_data_mux (
        .bus_i                     (cpu_bus_i),
        .interrupt_acknowledge_n_i (interrupt_acknowledge_n_i),
        .cs_i                      (cs_o),
        .device_rdata_i            (device_rdata_i),
        .ems_readback_i            (ems_readback),
        .data_bus_o                (data_bus_o),
        .data_bus_drive_o          (data_bus_drive_o)
    );

    peripheral_crossing u_peripheral_crossing (
        .clock                (clock),
        .peripheral_clock     (peripheral_clock),
        .reset                (reset),
        .keycode_i            (keycode_i),
        .keyboard_irq_i       (keyboard_irq_i),
        .send_clock_i         (send_clock_i),
        .port_b_i             (port_b_i),
        .timer_clock_o        (timer_clock_o),
        .keyboard_interrupt_o (keyboard_interrupt_o),
        .keycode_o            (keycode_o),
        .kbd_send_request_o   (kbd_send_request_o),
        .ps2_clock_out_o      (ps2_clock_out_o)
    );

endmodule

// ==== tb_xt_peripherals.sv ====
// Testbench for the XT peripheral glue logic
// Reference models for decode, EMS registers, window hits and read priority
// Keyboard crossing and timer clock checks

`timescale 1ns/10ps

module tb_xt_peripherals import xt_periph_pkg::*; ();

    logic          clock;
    logic          peripheral_clock;
    logic          reset;
    cpu_bus_t      bus;
    logic          ems_enable;
    logic [1:0]    ems_address;
    logic          ack_n;
    device_rdata_t rdata;
    logic [7:0]    keycode;
    logic          kbd_irq;
    logic          send_clock;
    logic [7:0]    port_b;
    chip_select_t  cs;
    logic [3:0]    window_hit;
    logic [7:0]    data_bus;
    logic          drive;
    logic          timer_clock;
    logic          kbd_interrupt;
    logic [7:0]    keycode_out;
    logic          send_request;
    logic          ps2_clock;

    integer       seed = 32'h43fd_2bb7;
    int           error_count;
    int           check_count;
    int           test_errors;
    int           pulses;
    int           rises;
    logic         prev;
    logic         checking;
    logic [31:0]  rnd;
    logic [31:0]  rnd2;
    logic [19:0]  addr;
    logic [7:0]   wdata;
    logic         model_en [4];
    logic [6:0]   model_page [4];
    chip_select_t exp_cs;
    logic [8:0]   exp_read;

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Peripheral clock rises at 10 ns, then every 14 ns
    initial begin
        peripheral_clock = 1'b0;
        #10;
        forever begin
            peripheral_clock = ~peripheral_clock;
            #7;
        end
    end

    xt_peripherals i_dut (
        .clock                     (clock),
        .peripheral_clock          (peripheral_clock),
        .reset                     (reset),
        .cpu_bus_i                 (bus),
        .ems_enable_i              (ems_enable),
        .ems_address_i             (ems_address),
        .interrupt_acknowledge_n_i (ack_n),
        .device_rdata_i            (rdata),
        .keycode_i                 (keycode),
        .keyboard_irq_i            (kbd_irq),
        .send_clock_i              (send_clock),
        .port_b_i                  (port_b),
        .cs_o                      (cs),
        .ems_window_hit_o          (window_hit),
        .data_bus_o                (data_bus),
        .data_bus_drive_o          (drive),
        .timer_clock_o             (timer_clock),
        .keyboard_interrupt_o      (kbd_interrupt),
        .keycode_o                 (keycode_out),
        .kbd_send_request_o        (send_request),
        .ps2_clock_out_o           (ps2_clock)
    );

    function automatic chip_select_t decode_ref(cpu_bus_t b, logic en);
        chip_select_t c;
        c = '1;
        if (!b.address_enable_n && b.address[9:8] == 2'b00) begin
            case (b.address[7:5])
                3'd0:    c.dma_n = 1'b0;
                3'd1:    c.pic_n = 1'b0;
                3'd2:    c.pit_n = 1'b0;
                3'd3:    c.ppi_n = 1'b0;
                3'd4:    c.dma_page_n = 1'b0;
                default: ;
            endcase
        end
        c.ems = !b.address_enable_n && en && (b.address[15:2] == 14'h0098);
        return c;
    endfunction

    // Returns {drive, data}
    function automatic logic [8:0] mux_ref(cpu_bus_t b, logic inta_n, chip_select_t c,
                                           device_rdata_t d, logic [7:0] ems_rd);
        if (!inta_n) return {1'b1, d.pic};
        if (!c.pic_n && !b.io_read_n) return {1'b1, d.pic};
        if (!c.pit_n && !b.io_read_n) return {1'b1, d.pit};
        if (!c.ppi_n && !b.io_read_n) return {1'b1, d.ppi};
        if (c.ems && !b.io_read_n) return {1'b1, ems_rd};
        return 9'h000;
    endfunction

    function automatic logic [7:0] ems_read_ref(logic [1:0] idx);
        return model_en[idx] ? {1'b0, model_page[idx]} : 8'hFF;
    endfunction

    function automatic logic [3:0] segment_nibble(logic [1:0] sel);
        case (sel)
            2'd0:    return 4'hA;
            2'd1:    return 4'hC;
            2'd2:    return 4'hD;
            default: return 4'hE;
        endcase
    endfunction

    function automatic logic [3:0] window_ref(logic [19:0] a, logic [1:0] sel);
        logic [3:0] hit;
        for (int w = 0; w < 4; w++) begin
            hit[w] = model_en[w] && a[19:16] == segment_nibble(sel) && a[15:14] == 2'(w);
        end
        return hit;
    endfunction

    function automatic void update_model(logic [1:0] idx, logic [7:0] value);
        if (value == 8'hFF) begin
            model_en[idx]   = 1'b0;
            model_page[idx] = 7'h7F;
        end else if (value < 8'h80) begin
            model_en[idx]   = 1'b1;
            model_page[idx] = value[6:0];
        end
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // Combinational outputs are stable at the falling edge
    always @(negedge clock) begin
        if (checking) begin
            exp_cs   = decode_ref(bus, ems_enable);
            exp_read = mux_ref(bus, ack_n, exp_cs, rdata, ems_read_ref(bus.address[1:0]));
            check("cs_o", 32'(cs), 32'(exp_cs));
            check("data_bus_o", 32'(data_bus), 32'(exp_read[7:0]));
            check("data_bus_drive_o", 32'(drive), 32'(exp_read[8]));
            check("ems_window_hit_o", 32'(window_hit),
                  32'(window_ref(bus.address, ems_address)));
            // DUT takes the write at the next rising edge
            if (exp_cs.ems && !bus.io_write_n) begin
                update_model(bus.address[1:0], bus.data);
            end
        end
    end

    task automatic drive_bus(input logic [19:0] a, input logic [7:0] wd, input logic rd_n,
                             input logic wr_n, input logic aen_n);
        @(posedge clock);
        #1;
        bus = '{address: a, data: wd, io_read_n: rd_n, io_write_n: wr_n,
                memory_read_n: 1'b1, address_enable_n: aen_n};
    endtask

    task automatic drive_keyboard(input logic irq, input logic [7:0] pb);
        @(posedge clock);
        #1;
        kbd_irq = irq;
        port_b  = pb;
    endtask

    task automatic end_test(input string name);
        @(negedge clock);
        #1;
        $display("test %-10s done, %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    task automatic wait_keycode(input logic [7:0] expected);
        int waited;
        waited = 0;
        while (keycode_out !== expected && waited < 20) begin
            @(posedge clock);
            #1;
            waited++;
        end
        check("keycode_o", 32'(keycode_out), 32'(expected));
    endtask

    task automatic wait_ps2(input logic expected);
        int waited;
        waited = 0;
        while (ps2_clock !== expected && waited < 10) begin
            @(negedge peripheral_clock);
            waited++;
        end
        if (ps2_clock !== expected) begin
            error_count++;
            $display("ps2_clock_out_o did not settle to %0b within 10 peripheral cycles",
                     expected);
        end
        // Level must hold once settled
        repeat (3) begin
            @(negedge peripheral_clock);
            check("ps2_clock_out_o", 32'(ps2_clock), 32'(expected));
        end
    endtask

    initial begin
        reset       = 1'b1;
        bus         = '{address: 20'h0, data: 8'h00, io_read_n: 1'b1, io_write_n: 1'b1,
                        memory_read_n: 1'b1, address_enable_n: 1'b1};
        ems_enable  = 1'b0;
        ems_address = 2'd0;
        ack_n       = 1'b1;
        rdata       = '0;
        keycode     = 8'h00;
        kbd_irq     = 1'b0;
        send_clock  = 1'b0;
        port_b      = 8'h00;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        checking    = 1'b0;
        for (int i = 0; i < 4; i++) begin
            model_en[i]   = 1'b0;
            model_page[i] = 7'h00;
        end
        repeat (2) @(posedge clock);
        #1;
        reset    = 1'b0;
        checking = 1'b1;

        // Random buses, some forced into the low I/O space or the EMS ports
        for (int n = 0; n < 200; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            if (rnd2[0]) rnd[9:8] = 2'b00;
            if (rnd2[1] && rnd2[2]) rnd[15:2] = 14'h0098;
            drive_bus(rnd[19:0], rnd[27:20], rnd2[6], 1'b1, rnd2[3] & rnd2[4]);
            ems_enable = rnd2[5];
        end
        end_test("decode");

        ems_enable = 1'b1;
        for (int n = 0; n < 40; n++) begin
            rnd = $random(seed);
            case (rnd[3:2])
                2'd0:    wdata = 8'hFF;
                2'd1:    wdata = {1'b1, rnd[14:8]};
                default: wdata = rnd[23:16];
            endcase
            drive_bus({18'h00098, rnd[1:0]}, wdata, 1'b1, 1'b0, 1'b0);
            drive_bus({18'h00098, rnd[5:4]}, 8'h00, 1'b0, 1'b1, 1'b0);
        end
        end_test("ems_regs");

        drive_bus(20'h00260, 8'h05, 1'b1, 1'b0, 1'b0);
        drive_bus(20'h00261, 8'hFF, 1'b1, 1'b0, 1'b0);
        drive_bus(20'h00262, 8'h12, 1'b1, 1'b0, 1'b0);
        drive_bus(20'h00263, 8'h33, 1'b1, 1'b0, 1'b0);
        for (int sel = 0; sel < 4; sel++) begin
            ems_address = 2'(sel);
            for (int n = 0; n < 30; n++) begin
                rnd  = $random(seed);
                addr = {rnd[20] ? segment_nibble(2'(sel)) : rnd[19:16], rnd[15:0]};
                drive_bus(addr, 8'h00, 1'b1, 1'b1, rnd[21]);
            end
        end
        end_test("ems_window");

        for (int n = 0; n < 150; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            addr = (rnd2[1:0] == 2'd0) ? {18'h00098, rnd[1:0]}
                                       : {12'h000, 1'b0, rnd2[1:0], rnd[4:0]};
            drive_bus(addr, 8'h00, rnd2[2], 1'b1, rnd2[3] & rnd2[4]);
            ack_n = rnd2[5] | rnd2[6];
            rdata = rnd[31:8];
        end
        ack_n = 1'b1;
        end_test("priority");

        drive_bus(20'h00000, 8'h00, 1'b1, 1'b1, 1'b1);
        for (int n = 0; n < 4; n++) begin
            rnd = $random(seed);
            @(posedge clock);
            #1;
            keycode = rnd[7:0];
            wait_keycode(rnd[7:0]);
        end
        send_clock = 1'b1;
        wait_ps2(1'b0);
        drive_keyboard(1'b0, 8'h40);
        pulses = 0;
        repeat (12) begin
            @(negedge peripheral_clock);
            if (send_request) pulses++;
        end
        check("kbd_send_request_o pulses", 32'(pulses), 32'd1);
        wait_ps2(1'b1);
        drive_keyboard(1'b1, 8'h40);
        wait_ps2(1'b0);
        check("keyboard_interrupt_o", 32'(kbd_interrupt), 32'd1);
        drive_keyboard(1'b0, 8'h40);
        wait_ps2(1'b1);
        check("keyboard_interrupt_o", 32'(kbd_interrupt), 32'd0);
        // Send clock low also holds the PS/2 clock low
        @(posedge clock);
        #1;
        send_clock = 1'b0;
        wait_ps2(1'b0);
        @(posedge clock);
        #1;
        send_clock = 1'b1;
        wait_ps2(1'b1);
        drive_keyboard(1'b0, 8'h00);
        wait_ps2(1'b0);
        end_test("keyboard");

        // 28 clock cycles cover 280 ns
        rises = 0;
        prev  = timer_clock;
        repeat (28) begin
            @(posedge clock);
            #1;
            if (timer_clock && !prev) rises++;
            prev = timer_clock;
        end
        if (rises < 8 || rises > 12) begin
            error_count++;
            $display("timer_clock_o rose %0d times in 280 ns, expected 8 to 12", rises);
        end
        end_test("timer");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
xt_periph_pkg.sv
io_decode.sv
ems_mapper.sv
cdc_sync.sv
peripheral_crossing.sv
read_data_mux.sv
xt_peripherals.sv
tb_xt_peripherals.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the XT peripheral testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_xt_peripherals &&
./obj_dir/Vtb_xt_peripherals | tee /dev/stderr | grep -qx "TEST PASS" || exit 1
